// ==== project.f ====
+incdir+.
conv_ctrl_pkg.sv
conv_data_pkg.sv
conv_ctrl_fsm.sv
conv_scan_counter.sv
conv_encoder.sv
conv_top.sv
conv_properties.sv
tb_conv_top.sv

// ==== tb_conv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module tb_conv_top;

localparam int WAIT_LIMIT = 200; // cycles per handshake wait
localparam int SEL_ACK    = 0;   // wait on o_ack
localparam int SEL_BR_REQ = 1;   // wait on o_br_req
localparam int SEL_ANY    = 2;   // wait on a word or the final ack

typedef struct packed
{
    conv_data_pkg::code_cfg_t    cfg;       // code for this command
    conv_ctrl_pkg::conv_op_e     op;        // command opcode
    logic                        din;       // encode bit
    logic                        slow_ack;  // random branch ack delays
    logic [`MAX_CODE_RATE - 1:0] exp_sym;   // expected o_enc_data at ack
    logic [10:0]                 exp_count; // expected branch words
} entry_t;

logic                        clk;
logic                        rst;
conv_data_pkg::code_cfg_t    i_cfg;
logic                        i_req;
conv_ctrl_pkg::conv_cmd_t    i_cmd;
logic                        i_br_ack;
logic                        o_ack;
logic [`MAX_CODE_RATE - 1:0] o_enc_data;
logic                        o_br_req;
conv_data_pkg::branch_word_t o_branch;

entry_t cmd_tab[$];                        // stimulus table
logic [`MAX_STATE_REG_NUM - 1:0] model_st; // reference encoder state
integer seed;                              // $random seed
int checks;
int value_errs;
int proto_errs;

initial clk = 1'b0;
always #50 clk = ~clk; // 100 ns period

conv_top i_conv_top
(
    .clk        (clk),
    .rst        (rst),
    .i_cfg      (i_cfg),
    .i_req      (i_req),
    .i_cmd      (i_cmd),
    .i_br_ack   (i_br_ack),
    .o_ack      (o_ack),
    .o_enc_data (o_enc_data),
    .o_br_req   (o_br_req),
    .o_branch   (o_branch)
);

// symbol for a state with one new bit at bit 0
// parity is summed bit by bit
function automatic logic [`MAX_CODE_RATE - 1:0] ref_sym
(
    input conv_data_pkg::code_cfg_t        cfg,
    input logic [`MAX_STATE_REG_NUM - 1:0] st,
    input logic                            din
);
    logic [`MAX_CONSTRAINT_LENGTH - 1:0] sreg;
    logic [`MAX_CODE_RATE - 1:0] sym;
    sreg = {st, din};
    sym  = '0;
    for (int i = 0; i < `MAX_CODE_RATE; i++)
    begin
        for (int j = 0; j < `MAX_CONSTRAINT_LENGTH; j++)
        begin
            sym[i] = sym[i] ^ (sreg[j] & cfg.poly[i][j]);
        end
    end
    return sym;
endfunction

function automatic conv_data_pkg::code_cfg_t make_cfg
(
    input logic [3:0]                          k,
    input logic [`MAX_CONSTRAINT_LENGTH - 1:0] p0,
    input logic [`MAX_CONSTRAINT_LENGTH - 1:0] p1,
    input logic [`MAX_CONSTRAINT_LENGTH - 1:0] p2
);
    conv_data_pkg::code_cfg_t cfg;
    cfg.k       = k;
    cfg.poly[0] = p0;
    cfg.poly[1] = p1;
    cfg.poly[2] = p2; // zero for rate 1/2
    return cfg;
endfunction

// append one command and run the model for its expectation
task automatic add_entry
(
    input conv_data_pkg::code_cfg_t cfg,
    input conv_ctrl_pkg::conv_op_e  op,
    input logic                     din,
    input logic                     slow
);
    entry_t e;
    e.cfg       = cfg;
    e.op        = op;
    e.din       = din;
    e.slow_ack  = slow;
    e.exp_sym   = '0; // clear and scan report zero
    e.exp_count = '0;
    if (op == conv_ctrl_pkg::OP_ENCODE)
    begin
        e.exp_sym = ref_sym(cfg, model_st, din);
        model_st  = {model_st[`MAX_STATE_REG_NUM - 2:0], din};
    end
    else if (op == conv_ctrl_pkg::OP_CLEAR)
    begin
        model_st = '0;
    end
    else
    begin
        e.exp_count = 11'(`RADIX) << (cfg.k - 4'd1); // 4 words per state
    end
    cmd_tab.push_back(e);
endtask

task automatic next_cycle;
    @(posedge clk);
    #1; // outputs have settled and inputs move here
endtask

// wait for a level with a timeout and hand back the cycles spent
task automatic wait_signal
(
    input  int    sel,
    input  logic  level,
    input  string what,
    output int    cycles
);
    int n;
    logic v;
    n = 0;
    v = (sel == SEL_ACK) ? o_ack : (sel == SEL_BR_REQ) ? o_br_req : (o_br_req || o_ack);
    while (v !== level && n < WAIT_LIMIT)
    begin
        next_cycle();
        n++;
        v = (sel == SEL_ACK) ? o_ack : (sel == SEL_BR_REQ) ? o_br_req : (o_br_req || o_ack);
    end
    if (v !== level)
    begin
        $display("timeout after %0d cycles waiting for %s at %0t", n, what, $time);
        $display("TEST FAILED");
        $finish;
    end
    else
    begin
        cycles = n;
    end
endtask

// take branch words until the final ack and check order and content
task automatic run_scan(input entry_t e);
    int cyc;
    int dly;
    int words;
    bit done;
    conv_data_pkg::branch_word_t exp_w;
    words = 0;
    done  = 0;
    while (!done)
    begin
        wait_signal(SEL_ANY, 1'b1, "a branch word or o_ack", cyc);
        if (o_ack)
        begin
            done = 1;
        end
        else
        begin
            exp_w.pair   = words[1:0];           // pair runs fastest
            exp_w.state  = 8'(words >> 2);
            exp_w.first  = ref_sym(e.cfg, exp_w.state, exp_w.pair[0]);
            exp_w.second = ref_sym(e.cfg, {exp_w.state[`MAX_STATE_REG_NUM - 2:0],
                                   exp_w.pair[0]}, exp_w.pair[1]);
            checks++;
            if (o_branch !== exp_w)
            begin
                value_errs++;
                $display("ERR %0t: word %0d got %h expected %h", $time, words, o_branch, exp_w);
            end
            dly = e.slow_ack ? int'($unsigned($random(seed)) % 6) : 0;
            repeat (dly) next_cycle(); // hold off the ack
            i_br_ack = 1'b1;
            wait_signal(SEL_BR_REQ, 1'b0, "o_br_req low", cyc);
            dly = e.slow_ack ? int'($unsigned($random(seed)) % 4) : 0;
            repeat (dly)
            begin
                next_cycle();
                checks++;
                if (o_br_req)
                begin
                    proto_errs++;
                    $display("ERR %0t: new word offered while i_br_ack high", $time);
                end
            end
            i_br_ack = 1'b0;
            words++;
        end
    end
    checks++;
    if (words != e.exp_count)
    begin
        value_errs++;
        $display("ERR %0t: scan gave %0d words, expected %0d", $time, words, e.exp_count);
    end
endtask

task automatic run_entry(input entry_t e);
    int cyc;
    i_cfg      = e.cfg;
    i_cmd.op   = e.op;
    i_cmd.data = e.din;
    i_req      = 1'b1;
    if (e.op == conv_ctrl_pkg::OP_SCAN)
    begin
        run_scan(e);
    end
    else
    begin
        wait_signal(SEL_ACK, 1'b1, "o_ack high", cyc);
        checks++;
        if (cyc != 2)
        begin
            proto_errs++;
            $display("ERR %0t: ack after %0d cycles, expected 2", $time, cyc);
        end
    end
    checks++;
    if (o_enc_data !== e.exp_sym)
    begin
        value_errs++;
        $display("ERR %0t: o_enc_data %h expected %h", $time, o_enc_data, e.exp_sym);
    end
    next_cycle(); // ack must outlast the request
    checks++;
    if (!o_ack)
    begin
        proto_errs++;
        $display("ERR %0t: o_ack fell while i_req high", $time);
    end
    i_req = 1'b0;
    wait_signal(SEL_ACK, 1'b0, "o_ack low", cyc);
    next_cycle();
endtask

initial
begin
    conv_data_pkg::code_cfg_t cfg_a;
    conv_data_pkg::code_cfg_t cfg_b;
    conv_data_pkg::code_cfg_t cfg_c;
    logic [11:0] bits_b;
    seed       = 9467;
    checks     = 0;
    value_errs = 0;
    proto_errs = 0;
    rst        = 1'b0;
    i_req      = 1'b0;
    i_cmd      = '0;
    i_cfg      = '0;
    i_br_ack   = 1'b0;
    model_st   = '0;
    cfg_a  = make_cfg(4'd3, 9'o7, 9'o5, 9'o0);       // K=3 rate 1/2
    cfg_b  = make_cfg(4'd9, 9'o557, 9'o663, 9'o711); // K=9 rate 1/3
    cfg_c  = make_cfg(4'd5, 9'o23, 9'o35, 9'o0);     // K=5 rate 1/2
    bits_b = 12'b1011_0011_1010;
    add_entry(cfg_a, conv_ctrl_pkg::OP_CLEAR, 1'b0, 1'b0);
    for (int i = 11; i >= 0; i--)
    begin
        add_entry(cfg_a, conv_ctrl_pkg::OP_ENCODE, bits_b[i], 1'b0);
    end
    add_entry(cfg_a, conv_ctrl_pkg::OP_CLEAR, 1'b1, 1'b0); // mid-sequence clear
    add_entry(cfg_a, conv_ctrl_pkg::OP_ENCODE, 1'b1, 1'b0);
    add_entry(cfg_a, conv_ctrl_pkg::OP_ENCODE, 1'b1, 1'b0);
    add_entry(cfg_b, conv_ctrl_pkg::OP_CLEAR, 1'b0, 1'b0);
    for (int i = 11; i >= 0; i--)
    begin
        add_entry(cfg_b, conv_ctrl_pkg::OP_ENCODE, ~bits_b[i], 1'b0);
    end
    add_entry(cfg_a, conv_ctrl_pkg::OP_SCAN, 1'b0, 1'b0);
    add_entry(cfg_a, conv_ctrl_pkg::OP_SCAN, 1'b0, 1'b1);
    add_entry(cfg_c, conv_ctrl_pkg::OP_SCAN, 1'b0, 1'b1);
    add_entry(cfg_c, conv_ctrl_pkg::OP_SCAN, 1'b0, 1'b0);
    add_entry(cfg_b, conv_ctrl_pkg::OP_ENCODE, 1'b1, 1'b0); // state kept through scans
    repeat (10) @(posedge clk);
    #1 rst = 1'b1;
    next_cycle();
    checks++;
    if (o_ack || o_br_req || o_enc_data !== '0 || o_branch !== '0)
    begin
        value_errs++;
        $display("ERR %0t: outputs not zero after reset", $time);
    end
    foreach (cmd_tab[i]) run_entry(cmd_tab[i]);
    $display("checks %0d, value errors %0d, protocol errors %0d", checks, value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0)
    begin
        $display("TEST PASSED");
    end
    else
    begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== conv_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_properties
(
    input wire logic                        clk,
    input wire logic                        rst,
    input wire logic                        i_req,
    input wire logic                        o_ack,
    input wire logic                        o_br_req,
    input wire logic                        i_br_ack,
    input wire conv_data_pkg::branch_word_t o_branch
);

// ack only ever answers a live request
ack_needs_req: assert property (@(posedge clk) disable iff (!rst) $rose(o_ack) |-> i_req)
    else $error("o_ack rose without i_req");

// ack holds until the request has dropped
ack_holds: assert property (@(posedge clk) disable iff (!rst) (o_ack && i_req) |=> o_ack)
    else $error("o_ack fell while i_req was high");

// branch request waits for its ack
br_req_holds: assert property (@(posedge clk) disable iff (!rst)
    (o_br_req && !i_br_ack) |=> o_br_req)
    else $error("o_br_req dropped before i_br_ack");

// word on offer must not move
branch_stable: assert property (@(posedge clk) disable iff (!rst)
    (o_br_req && $past(o_br_req)) |-> $stable(o_branch))
    else $error("o_branch changed while o_br_req was high");

// both requests quiet in reset
reset_quiet: assert property (@(posedge clk) !rst |-> (!o_ack && !o_br_req))
    else $error("o_ack or o_br_req high during reset");

endmodule

bind conv_top conv_properties i_conv_properties
(
    .clk      (clk),
    .rst      (rst),
    .i_req    (i_req),
    .o_ack    (o_ack),
    .o_br_req (o_br_req),
    .i_br_ack (i_br_ack),
    .o_branch (o_branch)
);

`default_nettype wire

// ==== conv_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_top
(
    input  logic                        clk,
    input  logic                        rst,
    input  conv_data_pkg::code_cfg_t    i_cfg,      // stable while i_req is high
    input  logic                        i_req,      // command request
    input  conv_ctrl_pkg::conv_cmd_t    i_cmd,      // op and encode bit
    input  logic                        i_br_ack,   // branch word accepted
    output logic                        o_ack,      // command complete
    output logic [`MAX_CODE_RATE - 1:0] o_enc_data, // valid while o_ack is high
    output logic                        o_br_req,   // branch word on offer
    output conv_data_pkg::branch_word_t o_branch    // stable while o_br_req is high
);

logic scan_clear;  // counter restart
logic scan_step;   // counter advance
logic scan_last;   // counter on final branch
logic enc_step;    // encode one bit
logic state_clear; // zero encoder state
logic br_load;     // capture branch word
logic [`DECODE_BIT_NUM - 1:0] scan_pair;     // counter pair digit
logic [`MAX_STATE_REG_NUM - 1:0] scan_state; // counter state digit

conv_ctrl_fsm i_conv_ctrl_fsm
(
    .clk           (clk),
    .rst           (rst),
    .i_req         (i_req),
    .i_cmd         (i_cmd),
    .i_br_ack      (i_br_ack),
    .i_scan_last   (scan_last),
    .o_ack         (o_ack),
    .o_br_req      (o_br_req),
    .o_scan_clear  (scan_clear),
    .o_scan_step   (scan_step),
    .o_enc_step    (enc_step),
    .o_state_clear (state_clear),
    .o_br_load     (br_load)
);

conv_scan_counter i_conv_scan_counter
(
    .clk     (clk),
    .rst     (rst),
    .i_cfg   (i_cfg),
    .i_clear (scan_clear),
    .i_step  (scan_step),
    .o_pair  (scan_pair),
    .o_state (scan_state),
    .o_last  (scan_last)
);

conv_encoder i_conv_encoder
(
    .clk           (clk),
    .rst           (rst),
    .i_cfg         (i_cfg),
    .i_bit         (i_cmd.data), // only sampled on an encode step
    .i_enc_step    (enc_step),
    .i_state_clear (state_clear),
    .i_br_load     (br_load),
    .i_pair        (scan_pair),
    .i_state       (scan_state),
    .o_enc_data    (o_enc_data),
    .o_branch      (o_branch)
);

endmodule

`default_nettype wire

// ==== conv_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_encoder
(
    input  logic                            clk,
    input  logic                            rst,
    input  conv_data_pkg::code_cfg_t        i_cfg,         // polynomials used for parity
    input  logic                            i_bit,         // bit to encode
    input  logic                            i_enc_step,    // register symbol and shift state
    input  logic                            i_state_clear, // zero the shift register
    input  logic                            i_br_load,     // capture branch word
    input  logic [`DECODE_BIT_NUM - 1:0]    i_pair,        // scan input pair
    input  logic [`MAX_STATE_REG_NUM - 1:0] i_state,       // scan state
    output logic [`MAX_CODE_RATE - 1:0]     o_enc_data,    // last encoded symbol
    output conv_data_pkg::branch_word_t     o_branch       // last captured branch word
);

logic [`MAX_STATE_REG_NUM - 1:0] enc_state; // encode mode state, bit 0 is newest
logic [`MAX_CODE_RATE - 1:0] enc_sym;     // symbol for enc_state plus i_bit
logic [`MAX_CODE_RATE - 1:0] first_sym;   // scan state with pair bit 0 appended
logic [`MAX_CODE_RATE - 1:0] second_sym;  // one step on, pair bit 1 appended
logic [`MAX_CONSTRAINT_LENGTH - 1:0] enc_reg;    // full register in encode mode
logic [`MAX_CONSTRAINT_LENGTH - 1:0] first_reg;  // full register for first transition
logic [`MAX_CONSTRAINT_LENGTH - 1:0] second_reg; // full register for second transition
conv_data_pkg::branch_word_t branch_nxt; // word offered to the branch register

// parity of the register under each generator polynomial
function automatic logic [`MAX_CODE_RATE - 1:0] parity_sym
(
    input logic [`MAX_CODE_RATE - 1:0][`MAX_CONSTRAINT_LENGTH - 1:0] poly,
    input logic [`MAX_CONSTRAINT_LENGTH - 1:0]                       sreg
);
    logic [`MAX_CODE_RATE - 1:0] sym;
    sym = '0;
    for (int i = 0; i < `MAX_CODE_RATE; i++)
    begin
        sym[i] = ^(sreg & poly[i]); // zero polynomial gives a zero bit
    end
    return sym;
endfunction

assign enc_reg    = {enc_state, i_bit}; // new bit enters at bit 0
assign first_reg  = {i_state, i_pair[0]};
assign second_reg = {i_state[`MAX_STATE_REG_NUM - 2:0], i_pair[0], i_pair[1]}; // shifted once

assign enc_sym    = parity_sym(i_cfg.poly, enc_reg);
assign first_sym  = parity_sym(i_cfg.poly, first_reg);
assign second_sym = parity_sym(i_cfg.poly, second_reg);

always_comb
begin
    branch_nxt.pair   = i_pair;
    branch_nxt.state  = i_state;
    branch_nxt.second = second_sym;
    branch_nxt.first  = first_sym;
end

// encode path, one bit per step
always_ff @(posedge clk or negedge rst)
begin
    if (!rst)
    begin
        enc_state  <= '0;
        o_enc_data <= '0;
    end
    else
    begin
        if (i_state_clear)
        begin
            enc_state <= '0;
        end
        else if (i_enc_step)
        begin
            enc_state <= {enc_state[`MAX_STATE_REG_NUM - 2:0], i_bit}; // shift left, take bit
        end

        if (i_enc_step)
        begin
            o_enc_data <= enc_sym;
        end
        else if (i_state_clear || i_br_load)
        begin
            o_enc_data <= '0; // clear and scan report no symbol
        end
    end
end

// branch word register, held while the word is on offer
always_ff @(posedge clk or negedge rst)
begin
    if (!rst)
    begin
        o_branch <= '0;
    end
    else if (i_br_load)
    begin
        o_branch <= branch_nxt;
    end
end

endmodule

`default_nettype wire

// ==== conv_scan_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_scan_counter
(
    input  logic                            clk,
    input  logic                            rst,
    input  conv_data_pkg::code_cfg_t        i_cfg,   // constraint length sets the bound
    input  logic                            i_clear, // back to the first branch
    input  logic                            i_step,  // move to the next branch
    output logic [`DECODE_BIT_NUM - 1:0]    o_pair,  // low digit, runs fastest
    output logic [`MAX_STATE_REG_NUM - 1:0] o_state, // high digit
    output logic                            o_last   // final branch of this K
);

logic [3:0] k_eff; // constraint length held inside the supported range
logic [`MAX_STATE_REG_NUM:0] state_span; // number of states, 2^(K-1)
logic [`MAX_STATE_REG_NUM - 1:0] state_max; // highest state index
logic pair_wrap; // pair digit at its top value

always_comb
begin
    if (i_cfg.k < 4'd3)
    begin
        k_eff = 4'd3;
    end
    else if (i_cfg.k > 4'(`MAX_CONSTRAINT_LENGTH))
    begin
        k_eff = 4'(`MAX_CONSTRAINT_LENGTH);
    end
    else
    begin
        k_eff = i_cfg.k;
    end
end

assign state_span = {{`MAX_STATE_REG_NUM{1'b0}}, 1'b1} << (k_eff - 4'd1);
assign state_max  = state_span[`MAX_STATE_REG_NUM - 1:0] - 1'b1; // 256 wraps to 255 at K=9
assign pair_wrap  = (o_pair == `DECODE_BIT_NUM'(`RADIX - 1));
assign o_last     = pair_wrap && (o_state == state_max);

always_ff @(posedge clk or negedge rst)
begin
    if (!rst)
    begin
        o_pair  <= '0;
        o_state <= '0;
    end
    else if (i_clear)
    begin
        o_pair  <= '0;
        o_state <= '0;
    end
    else if (i_step)
    begin
        if (pair_wrap)
        begin
            o_pair  <= '0;
            o_state <= o_state + 1'b1; // all four pairs done for this state
        end
        else
        begin
            o_pair <= o_pair + 1'b1;
        end
    end
end

endmodule

`default_nettype wire

// ==== conv_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl_fsm
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     i_req,         // command request, four-phase
    input  conv_ctrl_pkg::conv_cmd_t i_cmd,         // stable while i_req is high
    input  logic                     i_br_ack,      // branch word taken
    input  logic                     i_scan_last,   // counter sits on the final branch
    output logic                     o_ack,         // command complete
    output logic                     o_br_req,      // branch word offered
    output logic                     o_scan_clear,  // restart the trellis counter
    output logic                     o_scan_step,   // advance the trellis counter
    output logic                     o_enc_step,    // encode i_cmd.data and shift
    output logic                     o_state_clear, // zero the encoder state
    output logic                     o_br_load      // capture the current branch word
);

conv_ctrl_pkg::ctrl_state_e state_q;   // current controller state
conv_ctrl_pkg::ctrl_state_e state_nxt; // next controller state
logic last_q; // word now on the branch port is the final one

always_ff @(posedge clk or negedge rst)
begin
    if (!rst)
    begin
        state_q <= conv_ctrl_pkg::ST_IDLE;
        last_q  <= 1'b0;
    end
    else
    begin
        state_q <= state_nxt;
        if (o_scan_clear)
        begin
            last_q <= 1'b0; // fresh scan
        end
        else if (o_br_load)
        begin
            last_q <= i_scan_last; // remember if this load was the end
        end
    end
end

always_comb
begin
    state_nxt     = state_q;
    o_scan_clear  = 1'b0;
    o_scan_step   = 1'b0;
    o_enc_step    = 1'b0;
    o_state_clear = 1'b0;
    o_br_load     = 1'b0;
    case (state_q)
        conv_ctrl_pkg::ST_IDLE:
        begin
            if (i_req)
            begin
                case (i_cmd.op)
                    conv_ctrl_pkg::OP_ENCODE:
                    begin
                        o_enc_step = 1'b1; // result lands on the first edge
                        state_nxt  = conv_ctrl_pkg::ST_ENCODE;
                    end
                    conv_ctrl_pkg::OP_CLEAR:
                    begin
                        o_state_clear = 1'b1;
                        state_nxt     = conv_ctrl_pkg::ST_CLEAR;
                    end
                    conv_ctrl_pkg::OP_SCAN:
                    begin
                        o_scan_clear = 1'b1; // counter starts at pair 0 state 0
                        state_nxt    = conv_ctrl_pkg::ST_SCAN_SEND;
                    end
                    default:
                    begin
                        state_nxt = conv_ctrl_pkg::ST_DONE; // unknown op just acks
                    end
                endcase
            end
        end
        conv_ctrl_pkg::ST_ENCODE, conv_ctrl_pkg::ST_CLEAR:
        begin
            state_nxt = conv_ctrl_pkg::ST_DONE; // ack on the second edge
        end
        conv_ctrl_pkg::ST_SCAN_SEND:
        begin
            if (!i_br_ack) // previous handshake fully closed
            begin
                if (last_q)
                begin
                    state_nxt = conv_ctrl_pkg::ST_DONE;
                end
                else
                begin
                    o_br_load   = 1'b1;
                    o_scan_step = !i_scan_last; // next word computes while this one waits
                    state_nxt   = conv_ctrl_pkg::ST_SCAN_WAIT;
                end
            end
        end
        conv_ctrl_pkg::ST_SCAN_WAIT:
        begin
            if (i_br_ack)
            begin
                state_nxt = conv_ctrl_pkg::ST_SCAN_SEND; // drop request
            end
        end
        conv_ctrl_pkg::ST_DONE:
        begin
            if (!i_req)
            begin
                state_nxt = conv_ctrl_pkg::ST_IDLE; // ack falls after request
            end
        end
        default:
        begin
            state_nxt = conv_ctrl_pkg::ST_IDLE;
        end
    endcase
end

assign o_ack    = (state_q == conv_ctrl_pkg::ST_DONE);
assign o_br_req = (state_q == conv_ctrl_pkg::ST_SCAN_WAIT); // word already registered here

endmodule

`default_nettype wire

// ==== conv_data_pkg.sv ====
`default_nettype none

`include "conv_macros.svh"

package conv_data_pkg;

    // code configuration, must hold still while a request is up
    typedef struct packed
    {
        logic [3:0] k; // constraint length in range 3 to 9
        logic [`MAX_CODE_RATE - 1:0][`MAX_CONSTRAINT_LENGTH - 1:0] poly; // unused entry is zero
    } code_cfg_t;

    // one radix-4 trellis branch as sent on the branch port
    typedef struct packed
    {
        logic [`DECODE_BIT_NUM - 1:0]    pair;   // bit 0 goes in first
        logic [`MAX_STATE_REG_NUM - 1:0] state;  // starting state
        logic [`MAX_CODE_RATE - 1:0]     second; // symbol of second transition
        logic [`MAX_CODE_RATE - 1:0]     first;  // symbol of first transition
    } branch_word_t;

endpackage

`default_nettype wire

// ==== conv_ctrl_pkg.sv ====
`default_nettype none

package conv_ctrl_pkg;

    // command opcodes on the request port
    typedef enum logic [1:0]
    {
        OP_CLEAR  = 2'd0, // zero the encoder state
        OP_ENCODE = 2'd1, // encode one bit
        OP_SCAN   = 2'd2  // walk the whole trellis
    } conv_op_e;

    // controller states
    typedef enum logic [2:0]
    {
        ST_IDLE      = 3'd0, // waiting for a request
        ST_ENCODE    = 3'd1, // encode result settling
        ST_CLEAR     = 3'd2, // state zeroed
        ST_SCAN_SEND = 3'd3, // load next branch word once ack is low
        ST_SCAN_WAIT = 3'd4, // branch request up, waiting for ack
        ST_DONE      = 3'd5  // ack held until request drops
    } ctrl_state_e;

    // one command as seen on i_cmd
    typedef struct packed
    {
        conv_op_e op;   // what to do
        logic     data; // input bit for encode
    } conv_cmd_t;

endpackage

`default_nettype wire

// ==== conv_macros.svh ====
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// sizes shared by the codec front end

// longest supported code, sets polynomial and register width
`define MAX_CONSTRAINT_LENGTH 9

// output bits per input bit at rate 1/3
`define MAX_CODE_RATE 3

// state width is one less than the register
`define MAX_STATE_REG_NUM 8

// input pairs per state in the radix-4 trellis
`define RADIX 4

// bits in one input pair
`define DECODE_BIT_NUM 2

`endif
